/* hw/isa_pkg.sv */
package isa_pkg;

    localparam int REG_AW = 5; // register index width

    // major opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LB    = 6'h20;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // r-type funct field
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam logic [1:0] ALU_ADD   = 2'b00;
    localparam logic [1:0] ALU_SUB   = 2'b01;
    localparam logic [1:0] ALU_RTYPE = 2'b10; // execute looks at funct
    localparam logic [1:0] ALU_LOGIC = 2'b11;

    // zero width means no memory access
    localparam logic [1:0] WD_BYTE = 2'b01;
    localparam logic [1:0] WD_WORD = 2'b11;

    typedef struct packed {
        logic [5:0]        opcode;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
        logic [4:0]        shamt;
        logic [5:0]        funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]        opcode;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [15:0]       imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } j_fmt_t;

    // one instruction word, three field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

endpackage

/* hw/pipe_pkg.sv */
package pipe_pkg;

    localparam int DATA_W = 32;

    // queue entries, also the credits fetch holds after reset
    localparam int INGRESS_DEPTH = 4;

    // downstream slots available after reset
    localparam int EGRESS_CREDITS = 2;

    // counter must reach EGRESS_CREDITS itself
    localparam int CRED_W = $clog2(EGRESS_CREDITS + 1);

endpackage

/* hw/instr_ingress.sv */
`timescale 1ns/1ps

module instr_ingress import pipe_pkg::*; (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_instr_valid,
    input  logic [DATA_W-1:0] i_instr,
    input  logic [DATA_W-1:0] i_pc4,
    input  logic              i_pop,
    output logic              o_instr_credit,
    output logic              o_not_empty,
    output logic [DATA_W-1:0] o_head_instr,
    output logic [DATA_W-1:0] o_head_pc4
);

    typedef logic [$clog2(INGRESS_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(INGRESS_DEPTH+1)-1:0] cnt_t;

    logic [DATA_W-1:0] instr_mem [INGRESS_DEPTH];
    logic [DATA_W-1:0] pc4_mem   [INGRESS_DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic push;
    logic pop;

    assign push = i_instr_valid; // fetch only sends while holding a credit
    assign pop  = i_pop && o_not_empty;

    always_ff @(posedge clk) begin
        if (push) begin
            instr_mem[wr_ptr] <= i_instr;
            pc4_mem[wr_ptr]   <= i_pc4;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            o_instr_credit <= 1'b0;
        end else begin
            o_instr_credit <= pop; // one credit back per freed entry
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(INGRESS_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(INGRESS_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign o_not_empty  = (count != '0);
    assign o_head_instr = instr_mem[rd_ptr];
    assign o_head_pc4   = pc4_mem[rd_ptr];

endmodule

/* hw/register_file.sv */
`timescale 1ns/1ps

module register_file import isa_pkg::*, pipe_pkg::*; (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_we,
    input  logic [REG_AW-1:0] i_wr_addr,
    input  logic [DATA_W-1:0] i_wr_data,
    input  logic [REG_AW-1:0] i_rd_addr1,
    input  logic [REG_AW-1:0] i_rd_addr2,
    output logic [DATA_W-1:0] o_rd_data1,
    output logic [DATA_W-1:0] o_rd_data2
);

    logic [DATA_W-1:0] regs [2**REG_AW];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_wr_addr != '0) begin // $zero never takes a write
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // writeback in the same cycle wins over the stored value
    assign o_rd_data1 = (i_rd_addr1 == '0)                    ? '0        :
                        (i_we && i_wr_addr == i_rd_addr1)     ? i_wr_data :
                                                                regs[i_rd_addr1];

    assign o_rd_data2 = (i_rd_addr2 == '0)                    ? '0        :
                        (i_we && i_wr_addr == i_rd_addr2)     ? i_wr_data :
                                                                regs[i_rd_addr2];

endmodule

/* hw/control_unit.sv */
`timescale 1ns/1ps

module control_unit import isa_pkg::*; (
    input  logic [5:0] i_opcode,
    input  logic [5:0] i_funct,
    output logic       o_reg_dst,
    output logic       o_alu_src,
    output logic [1:0] o_alu_op,
    output logic       o_branch,
    output logic       o_jump,
    output logic       o_jump_reg,
    output logic       o_link,
    output logic       o_mem_read,
    output logic       o_mem_write,
    output logic       o_mem_to_reg,
    output logic       o_reg_write,
    output logic       o_imm_signed,
    output logic [1:0] o_width,
    output logic       o_illegal
);

    always_comb begin
        // anything not listed below leaves every control low
        o_reg_dst    = 1'b0;
        o_alu_src    = 1'b0;
        o_alu_op     = ALU_ADD;
        o_branch     = 1'b0;
        o_jump       = 1'b0;
        o_jump_reg   = 1'b0;
        o_link       = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_reg_write  = 1'b0;
        o_imm_signed = 1'b0;
        o_width      = 2'b00;
        o_illegal    = 1'b0;

        case (i_opcode)
            OP_RTYPE: begin
                case (i_funct)
                    FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLL: begin
                        o_reg_dst   = 1'b1;
                        o_alu_op    = ALU_RTYPE;
                        o_reg_write = 1'b1;
                    end
                    FN_JR: o_jump_reg = 1'b1;
                    FN_JALR: begin
                        o_jump_reg  = 1'b1;
                        o_link      = 1'b1; // return address into rd
                        o_reg_dst   = 1'b1;
                        o_reg_write = 1'b1;
                    end
                    default: o_illegal = 1'b1;
                endcase
            end
            OP_ADDI: begin
                o_alu_src    = 1'b1;
                o_reg_write  = 1'b1;
                o_imm_signed = 1'b1;
            end
            OP_ANDI, OP_ORI: begin
                o_alu_src   = 1'b1;
                o_alu_op    = ALU_LOGIC; // zero-extended operand
                o_reg_write = 1'b1;
            end
            OP_LUI: begin
                o_alu_src   = 1'b1;
                o_reg_write = 1'b1;
            end
            OP_LW, OP_LB: begin
                o_alu_src    = 1'b1;
                o_mem_read   = 1'b1;
                o_mem_to_reg = 1'b1;
                o_reg_write  = 1'b1;
                o_imm_signed = 1'b1;
                o_width      = (i_opcode == OP_LB) ? WD_BYTE : WD_WORD;
            end
            OP_SW: begin
                o_alu_src    = 1'b1;
                o_mem_write  = 1'b1;
                o_imm_signed = 1'b1;
                o_width      = WD_WORD;
            end
            OP_BEQ, OP_BNE: begin
                o_branch     = 1'b1;
                o_alu_op     = ALU_SUB; // compare by subtraction
                o_imm_signed = 1'b1;
            end
            OP_J: o_jump = 1'b1;
            OP_JAL: begin
                o_jump      = 1'b1;
                o_link      = 1'b1;
                o_reg_write = 1'b1;
            end
            default: o_illegal = 1'b1;
        endcase
    end

endmodule

/* hw/instruction_decode.sv */
`timescale 1ns/1ps

module instruction_decode import isa_pkg::*, pipe_pkg::*; (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_issue,
    input  logic [DATA_W-1:0] i_instr,
    input  logic [DATA_W-1:0] i_pc4,
    input  logic              i_wb_we,
    input  logic [REG_AW-1:0] i_wb_addr,
    input  logic [DATA_W-1:0] i_wb_data,
    output logic              o_dec_valid,
    output logic [REG_AW-1:0] o_rs,
    output logic [REG_AW-1:0] o_rt,
    output logic [REG_AW-1:0] o_rd,
    output logic [4:0]        o_shamt,
    output logic [DATA_W-1:0] o_reg_da,
    output logic [DATA_W-1:0] o_reg_db,
    output logic [DATA_W-1:0] o_immediate,
    output logic [DATA_W-1:0] o_jmp_addr,
    output logic [DATA_W-1:0] o_pc4,
    output logic              o_reg_dst,
    output logic              o_alu_src,
    output logic [1:0]        o_alu_op,
    output logic              o_branch,
    output logic              o_jump,
    output logic              o_jump_reg,
    output logic              o_link,
    output logic              o_mem_read,
    output logic              o_mem_write,
    output logic              o_mem_to_reg,
    output logic              o_reg_write,
    output logic              o_imm_signed,
    output logic [1:0]        o_width,
    output logic              o_illegal
);

    instr_u            iw;
    logic [DATA_W-1:0] rd_data1;
    logic [DATA_W-1:0] rd_data2;
    logic [DATA_W-1:0] imm_ext;
    logic [DATA_W-1:0] jmp_addr;
    logic              c_reg_dst, c_alu_src, c_branch, c_jump, c_jump_reg, c_link;
    logic              c_mem_read, c_mem_write, c_mem_to_reg, c_reg_write;
    logic              c_imm_signed, c_illegal;
    logic [1:0]        c_alu_op;
    logic [1:0]        c_width;

    assign iw = i_instr; // head of the ingress queue

    register_file u_regfile (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_we       (i_wb_we),
        .i_wr_addr  (i_wb_addr),
        .i_wr_data  (i_wb_data),
        .i_rd_addr1 (iw.r.rs),
        .i_rd_addr2 (iw.r.rt),
        .o_rd_data1 (rd_data1),
        .o_rd_data2 (rd_data2)
    );

    control_unit u_ctrl (
        .i_opcode     (iw.r.opcode),
        .i_funct      (iw.r.funct),
        .o_reg_dst    (c_reg_dst),
        .o_alu_src    (c_alu_src),
        .o_alu_op     (c_alu_op),
        .o_branch     (c_branch),
        .o_jump       (c_jump),
        .o_jump_reg   (c_jump_reg),
        .o_link       (c_link),
        .o_mem_read   (c_mem_read),
        .o_mem_write  (c_mem_write),
        .o_mem_to_reg (c_mem_to_reg),
        .o_reg_write  (c_reg_write),
        .o_imm_signed (c_imm_signed),
        .o_width      (c_width),
        .o_illegal    (c_illegal)
    );

    always_comb begin
        if (iw.i.opcode == OP_LUI) begin
            imm_ext = {iw.i.imm16, 16'h0000}; // upper half load
        end else if (c_imm_signed) begin
            imm_ext = {{16{iw.i.imm16[15]}}, iw.i.imm16};
        end else begin
            imm_ext = {16'h0000, iw.i.imm16};
        end
    end

    // pseudo-direct target within the current 256 MB region
    assign jmp_addr = {i_pc4[31:28], iw.j.target26, 2'b00};

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dec_valid <= 1'b0;
            {o_reg_dst, o_alu_src, o_alu_op, o_branch, o_jump, o_jump_reg, o_link,
             o_mem_read, o_mem_write, o_mem_to_reg, o_reg_write, o_imm_signed,
             o_width, o_illegal} <= '0;
        end else begin
            o_dec_valid <= i_issue; // single-cycle pulse per issue
            if (i_issue) begin
                {o_reg_dst, o_alu_src, o_alu_op, o_branch, o_jump, o_jump_reg, o_link,
                 o_mem_read, o_mem_write, o_mem_to_reg, o_reg_write, o_imm_signed,
                 o_width, o_illegal} <=
                    {c_reg_dst, c_alu_src, c_alu_op, c_branch, c_jump, c_jump_reg, c_link,
                     c_mem_read, c_mem_write, c_mem_to_reg, c_reg_write, c_imm_signed,
                     c_width, c_illegal};
            end
        end
    end

    // datapath fields, only meaningful alongside o_dec_valid
    always_ff @(posedge clk) begin
        if (i_issue) begin
            o_rs        <= iw.r.rs;
            o_rt        <= iw.r.rt;
            o_rd        <= iw.r.rd;
            o_shamt     <= iw.r.shamt;
            o_reg_da    <= rd_data1;
            o_reg_db    <= rd_data2;
            o_immediate <= imm_ext;
            o_jmp_addr  <= jmp_addr;
            o_pc4       <= i_pc4;
        end
    end

endmodule

/* hw/decode_egress.sv */
`timescale 1ns/1ps

module decode_egress import pipe_pkg::*; (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_not_empty,
    input  logic i_dec_credit,
    output logic o_issue
);

    logic [CRED_W-1:0] credits; // free downstream slots

    assign o_issue = i_not_empty && (credits != '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            credits <= CRED_W'(EGRESS_CREDITS);
        end else if (o_issue && !i_dec_credit) begin
            credits <= credits - 1'b1;
        end else if (i_dec_credit && !o_issue) begin
            credits <= credits + 1'b1;
        end
        // issue and returned credit together cancel out
    end

endmodule

/* hw/decode_top.sv */
`timescale 1ns/1ps

module decode_top import isa_pkg::*, pipe_pkg::*; (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_instr_valid,
    input  logic [DATA_W-1:0] i_instr,
    input  logic [DATA_W-1:0] i_pc4,
    output logic              o_instr_credit,
    input  logic              i_wb_we,
    input  logic [REG_AW-1:0] i_wb_addr,
    input  logic [DATA_W-1:0] i_wb_data,
    input  logic              i_dec_credit,
    output logic              o_dec_valid,
    output logic [REG_AW-1:0] o_rs,
    output logic [REG_AW-1:0] o_rt,
    output logic [REG_AW-1:0] o_rd,
    output logic [4:0]        o_shamt,
    output logic [DATA_W-1:0] o_reg_da,
    output logic [DATA_W-1:0] o_reg_db,
    output logic [DATA_W-1:0] o_immediate,
    output logic [DATA_W-1:0] o_jmp_addr,
    output logic [DATA_W-1:0] o_pc4,
    output logic              o_reg_dst,
    output logic              o_alu_src,
    output logic [1:0]        o_alu_op,
    output logic              o_branch,
    output logic              o_jump,
    output logic              o_jump_reg,
    output logic              o_link,
    output logic              o_mem_read,
    output logic              o_mem_write,
    output logic              o_mem_to_reg,
    output logic              o_reg_write,
    output logic              o_imm_signed,
    output logic [1:0]        o_width,
    output logic              o_illegal
);

    logic              issue;
    logic              not_empty;
    logic [DATA_W-1:0] head_instr;
    logic [DATA_W-1:0] head_pc4;

    instr_ingress u_ingress (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .i_pc4          (i_pc4),
        .i_pop          (issue),
        .o_instr_credit (o_instr_credit),
        .o_not_empty    (not_empty),
        .o_head_instr   (head_instr),
        .o_head_pc4     (head_pc4)
    );

    instruction_decode u_decode (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_issue      (issue),
        .i_instr      (head_instr),
        .i_pc4        (head_pc4),
        .i_wb_we      (i_wb_we),
        .i_wb_addr    (i_wb_addr),
        .i_wb_data    (i_wb_data),
        .o_dec_valid  (o_dec_valid),
        .o_rs         (o_rs),
        .o_rt         (o_rt),
        .o_rd         (o_rd),
        .o_shamt      (o_shamt),
        .o_reg_da     (o_reg_da),
        .o_reg_db     (o_reg_db),
        .o_immediate  (o_immediate),
        .o_jmp_addr   (o_jmp_addr),
        .o_pc4        (o_pc4),
        .o_reg_dst    (o_reg_dst),
        .o_alu_src    (o_alu_src),
        .o_alu_op     (o_alu_op),
        .o_branch     (o_branch),
        .o_jump       (o_jump),
        .o_jump_reg   (o_jump_reg),
        .o_link       (o_link),
        .o_mem_read   (o_mem_read),
        .o_mem_write  (o_mem_write),
        .o_mem_to_reg (o_mem_to_reg),
        .o_reg_write  (o_reg_write),
        .o_imm_signed (o_imm_signed),
        .o_width      (o_width),
        .o_illegal    (o_illegal)
    );

    // one strobe drives pop, output load and credit decrement
    decode_egress u_egress (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_not_empty  (not_empty),
        .i_dec_credit (i_dec_credit),
        .o_issue      (issue)
    );

endmodule

/* test/tb_decode_top.sv */
`timescale 1ns/1ps

module tb_decode_top import isa_pkg::*, pipe_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 3;
    localparam int N_INSTR      = 400;
    localparam int WORST_CYCLES = 40;  // per instruction, covers withheld credit phases
    localparam longint WATCHDOG_NS = longint'(N_INSTR * WORST_CYCLES + 50) * CLK_PERIOD;

    localparam logic [5:0] RTYPE_FNS [8] = '{FN_ADD, FN_SUB, FN_AND, FN_OR,
                                             FN_SLT, FN_SLL, FN_JR, FN_JALR};
    localparam logic [5:0] IJ_OPS [11] = '{OP_ADDI, OP_ANDI, OP_ORI, OP_LUI, OP_LW, OP_LB,
                                           OP_SW, OP_BEQ, OP_BNE, OP_J, OP_JAL};

    logic              clk;
    logic              i_rst_n;
    logic              i_instr_valid;
    logic [DATA_W-1:0] i_instr;
    logic [DATA_W-1:0] i_pc4;
    logic              o_instr_credit;
    logic              i_wb_we;
    logic [REG_AW-1:0] i_wb_addr;
    logic [DATA_W-1:0] i_wb_data;
    logic              i_dec_credit;
    logic              o_dec_valid;
    logic [REG_AW-1:0] o_rs, o_rt, o_rd;
    logic [4:0]        o_shamt;
    logic [DATA_W-1:0] o_reg_da, o_reg_db, o_immediate, o_jmp_addr, o_pc4;
    logic              o_reg_dst, o_alu_src, o_branch, o_jump, o_jump_reg, o_link;
    logic              o_mem_read, o_mem_write, o_mem_to_reg, o_reg_write, o_imm_signed;
    logic              o_illegal;
    logic [1:0]        o_alu_op, o_width;
    logic [15:0]       ctrl_vec;

    logic [DATA_W-1:0] model_regs [2**REG_AW];
    logic [DATA_W-1:0] sb_instr [$];  // sent, not yet seen at the output
    logic [DATA_W-1:0] sb_pc4 [$];
    int unsigned fetch_credits;
    int unsigned outstanding;         // outputs seen, credit not yet returned
    int unsigned sent_cnt, recv_cnt, returned_cnt;
    int unsigned value_errs, protocol_errs;
    int unsigned cycle_cnt;
    bit          sent_any;

    decode_top dut (.*);

    assign ctrl_vec = {o_reg_dst, o_alu_src, o_alu_op, o_branch, o_jump, o_jump_reg, o_link,
                       o_mem_read, o_mem_write, o_mem_to_reg, o_reg_write, o_imm_signed,
                       o_width, o_illegal};

    always #(CLK_PERIOD / 2) clk = ~clk;

    // nothing may leave the stage before fetch has sent anything
    idle_after_reset: assert property (@(posedge clk) disable iff (!i_rst_n)
        !sent_any |-> (!o_dec_valid && !o_instr_credit && ctrl_vec == 16'h0))
    else begin
        value_errs++;
        $display("Error at %0t ns: idle outputs = %h, expected 0", $time,
                 {o_dec_valid, o_instr_credit, ctrl_vec});
    end

    function automatic bit listed_opcode(logic [5:0] op);
        return op inside {OP_RTYPE, OP_ADDI, OP_ANDI, OP_ORI, OP_LUI, OP_LW, OP_LB,
                          OP_SW, OP_BEQ, OP_BNE, OP_J, OP_JAL};
    endfunction

    function automatic bit listed_funct(logic [5:0] fn);
        return fn inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLL, FN_JR, FN_JALR};
    endfunction

    // reference control table, same bit order as ctrl_vec
    function automatic logic [15:0] expect_ctrl(logic [5:0] op, logic [5:0] fn);
        logic       reg_dst, alu_src, branch, jump, jump_reg, link;
        logic       mem_rd, mem_wr, mem_to_reg, reg_wr, imm_s, illegal;
        logic [1:0] alu_op, width;
        {reg_dst, alu_src, branch, jump, jump_reg, link} = '0;
        {mem_rd, mem_wr, mem_to_reg, reg_wr, imm_s, illegal} = '0;
        alu_op = ALU_ADD;
        width  = 2'b00;
        case (op)
            OP_RTYPE: begin
                if (fn == FN_JR) begin
                    jump_reg = 1'b1;
                end else if (fn == FN_JALR) begin
                    {jump_reg, link, reg_dst, reg_wr} = 4'b1111;
                end else if (listed_funct(fn)) begin
                    {reg_dst, reg_wr} = 2'b11;
                    alu_op = ALU_RTYPE;
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_ADDI: {alu_src, reg_wr, imm_s} = 3'b111;
            OP_ANDI, OP_ORI: begin
                {alu_src, reg_wr} = 2'b11;
                alu_op = ALU_LOGIC;
            end
            OP_LUI: {alu_src, reg_wr} = 2'b11;
            OP_LW, OP_LB: begin
                {alu_src, mem_rd, mem_to_reg, reg_wr, imm_s} = 5'b11111;
                width = (op == OP_LB) ? WD_BYTE : WD_WORD;
            end
            OP_SW: begin
                {alu_src, mem_wr, imm_s} = 3'b111;
                width = WD_WORD;
            end
            OP_BEQ, OP_BNE: begin
                {branch, imm_s} = 2'b11;
                alu_op = ALU_SUB;
            end
            OP_J: jump = 1'b1;
            OP_JAL: {jump, link, reg_wr} = 3'b111;
            default: illegal = 1'b1;
        endcase
        return {reg_dst, alu_src, alu_op, branch, jump, jump_reg, link,
                mem_rd, mem_wr, mem_to_reg, reg_wr, imm_s, width, illegal};
    endfunction

    function automatic logic [31:0] expect_imm(logic [31:0] w);
        logic [5:0] op;
        op = w[31:26];
        if (op == OP_LUI) return {w[15:0], 16'h0000};
        if (op inside {OP_ADDI, OP_LW, OP_LB, OP_SW, OP_BEQ, OP_BNE}) begin
            return {{16{w[15]}}, w[15:0]};
        end
        return {16'h0000, w[15:0]};
    endfunction

    // wb values still on the bus are the ones seen during the issue cycle
    function automatic logic [31:0] expected_read(logic [4:0] addr);
        if (addr == 5'd0) return 32'h0;
        if (i_wb_we && i_wb_addr == addr) return i_wb_data;
        return model_regs[addr];
    endfunction

    function automatic logic [31:0] make_instr();
        logic [31:0] w;
        int          kind;
        w    = $urandom;
        kind = $urandom_range(0, 9);
        if ($urandom_range(0, 1) == 1) w[25:16] = w[25:16] & 10'b00111_00111; // r0..r7
        if (kind < 4) begin
            w[31:26] = OP_RTYPE;
            w[5:0]   = RTYPE_FNS[$urandom_range(0, 7)];
        end else if (kind < 8) begin
            w[31:26] = IJ_OPS[$urandom_range(0, 10)];
        end else if (kind == 8) begin
            do w[31:26] = 6'($urandom); while (listed_opcode(w[31:26]));
        end else begin
            w[31:26] = OP_RTYPE;
            do w[5:0] = 6'($urandom); while (listed_funct(w[5:0]));
        end
        return w;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_output();
        logic [31:0] w;
        logic [31:0] pc;
        if (sb_instr.size() == 0) begin
            protocol_errs++;
            $display("o_dec_valid at %0t ns with no instruction outstanding", $time);
            return;
        end
        w  = sb_instr.pop_front();
        pc = sb_pc4.pop_front();
        check_field("o_rs", 32'(o_rs), 32'(w[25:21]));
        check_field("o_rt", 32'(o_rt), 32'(w[20:16]));
        check_field("o_rd", 32'(o_rd), 32'(w[15:11]));
        check_field("o_shamt", 32'(o_shamt), 32'(w[10:6]));
        check_field("o_reg_da", o_reg_da, expected_read(w[25:21]));
        check_field("o_reg_db", o_reg_db, expected_read(w[20:16]));
        check_field("o_immediate", o_immediate, expect_imm(w));
        check_field("o_jmp_addr", o_jmp_addr, {pc[31:28], w[25:0], 2'b00});
        check_field("o_pc4", o_pc4, pc);
        check_field("control outputs", 32'(ctrl_vec), 32'(expect_ctrl(w[31:26], w[5:0])));
        recv_cnt++;
        outstanding++;
        assert (outstanding <= EGRESS_CREDITS) else begin
            protocol_errs++;
            $display("%0d results without downstream credit at %0t ns", outstanding, $time);
        end
    endtask

    // one negedge: check, update models, drive next inputs
    task automatic cycle_step();
        bit withhold;
        if (o_dec_valid) check_output();
        if (o_instr_credit) begin
            fetch_credits++;
            returned_cnt++;
            assert (fetch_credits <= INGRESS_DEPTH) else begin
                protocol_errs++;
                $display("fetch credit returned for no entry at %0t ns", $time);
            end
        end
        if (i_wb_we && i_wb_addr != 5'd0) model_regs[i_wb_addr] = i_wb_data; // took effect

        if (fetch_credits > 0 && sent_cnt < N_INSTR && $urandom_range(0, 3) != 0) begin
            i_instr_valid = 1'b1;
            i_instr       = make_instr();
            i_pc4         = $urandom & 32'hffff_fffc;
            sb_instr.push_back(i_instr);
            sb_pc4.push_back(i_pc4);
            fetch_credits--;
            sent_cnt++;
            sent_any = 1'b1;
        end else begin
            i_instr_valid = 1'b0;
        end

        withhold = ((cycle_cnt / 32) % 2) == 1; // long stretches of back-pressure
        if (!withhold && outstanding > 0 && $urandom_range(0, 2) != 0) begin
            i_dec_credit = 1'b1;
            outstanding--;
        end else begin
            i_dec_credit = 1'b0;
        end

        i_wb_we   = ($urandom_range(0, 1) == 1);
        i_wb_addr = ($urandom_range(0, 1) == 1) ? 5'($urandom_range(0, 7)) : 5'($urandom);
        i_wb_data = $urandom;
        cycle_cnt++;
    endtask

    initial begin
        void'($urandom(32'h3cb8));
        clk           = 1'b0;
        i_rst_n       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_pc4         = '0;
        i_wb_we       = 1'b0;
        i_wb_addr     = '0;
        i_wb_data     = '0;
        i_dec_credit  = 1'b0;
        fetch_credits = INGRESS_DEPTH;
        {outstanding, sent_cnt, recv_cnt, returned_cnt} = '0;
        {value_errs, protocol_errs, cycle_cnt} = '0;
        sent_any = 1'b0;
        for (int i = 0; i < 2**REG_AW; i++) begin
            model_regs[i] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        // run until every result is out and fetch holds all its credits again
        while (recv_cnt < N_INSTR || fetch_credits < INGRESS_DEPTH) begin
            @(negedge clk);
            cycle_step();
        end

        // idle tail so a duplicated result or an extra credit still shows up
        repeat (INGRESS_DEPTH + 2) begin
            @(negedge clk);
            cycle_step();
        end

        assert (returned_cnt == sent_cnt) else begin
            protocol_errs++;
            $display("fetch got %0d credits back for %0d instructions", returned_cnt, sent_cnt);
        end

        $display("errors: %0d value, %0d protocol", value_errs, protocol_errs);
        if (value_errs == 0 && protocol_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: only %0d of %0d results seen by %0t ns", recv_cnt, N_INSTR, $time);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* filelist.f */
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/instr_ingress.sv
hw/register_file.sv
hw/control_unit.sv
hw/instruction_decode.sv
hw/decode_egress.sv
hw/decode_top.sv
test/tb_decode_top.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	@./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
